//--- verilog/llc_cfg_defines.svh
// Cache geometry for the configuration and flush controller
// LLC_SET_ASSO must stay below LLC_REG_WIDTH so a way mask fits one register
// Lines per way are 2**LLC_INDEX_LEN and each flush walks every line of a way

`ifndef LLC_CFG_DEFINES_SVH
`define LLC_CFG_DEFINES_SVH

// Number of ways, one bit per way in every mask register
`define LLC_SET_ASSO 4

// Index bits of an address, 16 lines per way
`define LLC_INDEX_LEN 4

// Blocks per cache line
`define LLC_NUM_BLOCKS 8

// Block offset plus byte offset bits below the index
`define LLC_OFFSET_LEN 6

// Full address width of the cached port
`define LLC_ADDR_WIDTH 32

// Width of one configuration register, 8-byte aligned map
`define LLC_REG_WIDTH 64

// Version word returned by the Version register
`define LLC_VERSION 64'h0000_0000_0001_0200

`endif

//--- verilog/llc_cfg_pkg.sv
// Shared types of the LLC configuration block
// All widths derive from the geometry macros in the defines header

`include "llc_cfg_defines.svh"

`default_nettype none

package llc_cfg_pkg;

  // One bit per cache way
  typedef logic [`LLC_SET_ASSO-1:0]   way_t;

  // Line index inside one way
  typedef logic [`LLC_INDEX_LEN-1:0]  index_t;

  // Address on the cached port
  typedef logic [`LLC_ADDR_WIDTH-1:0] addr_t;

  // One configuration register word
  typedef logic [`LLC_REG_WIDTH-1:0]  reg_data_t;

  // Register index, byte address bits [5:3] of the register map
  typedef enum logic [2:0] {
    reg_cfg_spm    = 3'd0,
    reg_cfg_flush  = 3'd1,
    reg_flushed    = 3'd2,
    reg_bist_out   = 3'd3,
    reg_set_asso   = 3'd4,
    reg_num_lines  = 3'd5,
    reg_num_blocks = 3'd6,
    reg_version    = 3'd7
  } reg_idx_e;

endpackage

`default_nettype wire

//--- verilog/llc_cfg_regs.sv
// Register bank of the LLC configuration block
// Only the low LLC_SET_ASSO bits of CfgSpm and CfgFlush are writable
// Host writes to those two registers are dropped while cfg_lock_i is high
// Reads are combinational, upper bits of the way registers read as zero

`include "llc_cfg_defines.svh"

`default_nettype none

module llc_cfg_regs (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Host register port
  input  logic                          cfg_we_i,
  input  llc_cfg_pkg::reg_idx_e         cfg_waddr_i,
  input  llc_cfg_pkg::reg_data_t        cfg_wdata_i,
  input  llc_cfg_pkg::reg_idx_e         cfg_raddr_i,
  output llc_cfg_pkg::reg_data_t        cfg_rdata_o,
  // Tag storage BIST result
  input  logic                          bist_valid_i,
  input  llc_cfg_pkg::way_t             bist_res_i,
  // Update paths from flush control
  input  logic                          cfg_lock_i,
  input  logic                          flushed_we_i,
  input  llc_cfg_pkg::way_t             flushed_d_i,
  input  logic                          flush_clr_i,
  input  logic                          spm_we_i,
  input  llc_cfg_pkg::way_t             spm_d_i,
  // Register state towards flush control
  output logic                          cfg_written_o,
  output llc_cfg_pkg::way_t             spm_q_o,
  output llc_cfg_pkg::way_t             flush_q_o,
  output llc_cfg_pkg::way_t             flushed_q_o
);
  import llc_cfg_pkg::*;

  // Fixed read-only register contents
  localparam reg_data_t set_asso_val   = reg_data_t'(`LLC_SET_ASSO);
  localparam reg_data_t num_lines_val  = reg_data_t'(1 << `LLC_INDEX_LEN);
  localparam reg_data_t num_blocks_val = reg_data_t'(`LLC_NUM_BLOCKS);
  localparam reg_data_t version_val    = `LLC_VERSION;

  way_t spm_q;
  way_t flush_q;
  way_t flushed_q;
  way_t bist_q;
  way_t wr_way;
  logic wr_ok;
  logic wr_spm;
  logic wr_flush;

  ////////////////////
  // Write filtering
  ////////////////////

  // Accepted host write, blocked while a flush or the BIST wait is running
  assign wr_ok    = cfg_we_i & ~cfg_lock_i;
  assign wr_spm   = wr_ok & (cfg_waddr_i == reg_cfg_spm);
  assign wr_flush = wr_ok & (cfg_waddr_i == reg_cfg_flush);
  // Reserved upper bits are dropped here
  assign wr_way   = cfg_wdata_i[`LLC_SET_ASSO-1:0];

  // Either writable register starts a flush sequence
  assign cfg_written_o = wr_spm | wr_flush;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      spm_q     <= '0;
      flush_q   <= '0;
      flushed_q <= '0;
      bist_q    <= '0;
    end else begin
      // BIST result seeds the SPM lock, never at the same time as a host write
      if (spm_we_i) begin
        spm_q <= spm_d_i;
      end else if (wr_spm) begin
        spm_q <= wr_way;
      end
      // Flush control clears the request when the sequence ends
      if (flush_clr_i) begin
        flush_q <= '0;
      end else if (wr_flush) begin
        flush_q <= wr_way;
      end
      // Flushed is only ever written by flush control
      if (flushed_we_i) begin
        flushed_q <= flushed_d_i;
      end
      if (bist_valid_i) begin
        bist_q <= bist_res_i;
      end
    end
  end

  ////////////////////
  // Read mux
  ////////////////////

  always_comb begin
    unique case (cfg_raddr_i)
      reg_cfg_spm:    cfg_rdata_o = reg_data_t'(spm_q);
      reg_cfg_flush:  cfg_rdata_o = reg_data_t'(flush_q);
      reg_flushed:    cfg_rdata_o = reg_data_t'(flushed_q);
      reg_bist_out:   cfg_rdata_o = reg_data_t'(bist_q);
      reg_set_asso:   cfg_rdata_o = set_asso_val;
      reg_num_lines:  cfg_rdata_o = num_lines_val;
      reg_num_blocks: cfg_rdata_o = num_blocks_val;
      reg_version:    cfg_rdata_o = version_val;
      default:        cfg_rdata_o = '0;
    endcase
  end

  // State for flush control and the cache
  assign spm_q_o     = spm_q;
  assign flush_q_o   = flush_q;
  assign flushed_q_o = flushed_q;

endmodule

`default_nettype wire

//--- verilog/llc_flush_ctrl.sv
// BIST wait and way flush sequencer of the LLC configuration block
// Holds the cache port isolated from reset until the BIST result arrives
// One descriptor per line of each selected way, lowest way first
// Every completion must follow the acceptance of its descriptor

`include "llc_cfg_defines.svh"

`default_nettype none

module llc_flush_ctrl (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Tag storage BIST
  input  logic               bist_valid_i,
  input  llc_cfg_pkg::way_t  bist_res_i,
  // Register bank state
  input  logic               cfg_written_i,
  input  llc_cfg_pkg::way_t  spm_q_i,
  input  llc_cfg_pkg::way_t  flush_q_i,
  input  llc_cfg_pkg::way_t  flushed_q_i,
  // Cache port status
  input  logic               llc_isolated_i,
  input  logic               aw_busy_i,
  input  logic               ar_busy_i,
  input  logic               flush_ready_i,
  input  logic               flush_done_i,
  output logic               llc_isolate_o,
  // Register bank updates
  output logic               cfg_lock_o,
  output logic               flushed_we_o,
  output llc_cfg_pkg::way_t  flushed_d_o,
  output logic               flush_clr_o,
  output logic               spm_we_o,
  output llc_cfg_pkg::way_t  spm_d_o,
  // Flush descriptor
  output logic               flush_valid_o,
  output llc_cfg_pkg::addr_t flush_addr_o,
  output llc_cfg_pkg::way_t  flush_way_o
);
  import llc_cfg_pkg::*;

  localparam int unsigned num_lines = 1 << `LLC_INDEX_LEN;
  localparam int unsigned tag_len   = `LLC_ADDR_WIDTH - `LLC_INDEX_LEN - `LLC_OFFSET_LEN;

  typedef enum logic [2:0] {
    st_pre_init,
    st_idle,
    st_wait_iso,
    st_wait_busy,
    st_init,
    st_send,
    st_wait_done,
    st_end
  } state_e;

  // One extra bit so the full line count fits
  typedef logic [`LLC_INDEX_LEN:0] outst_t;

  state_e state_d, state_q;
  way_t   to_flush_d, to_flush_q;
  way_t   way_sel;
  index_t send_cnt_q;
  outst_t outst_q;
  logic   cnt_load;
  logic   send_inc;
  logic   done_dec;

  // Lowest set bit as one-hot, x & -x
  assign way_sel = to_flush_q & (~to_flush_q + way_t'(1));

  ////////////////////
  // Sequencer
  ////////////////////

  always_comb begin
    state_d      = state_q;
    to_flush_d   = to_flush_q;
    flushed_we_o = 1'b0;
    flushed_d_o  = flushed_q_i;
    flush_clr_o  = 1'b0;
    cnt_load     = 1'b0;
    send_inc     = 1'b0;
    unique case (state_q)
      st_pre_init: begin
        // BIST errors become SPM ways and count as flushed, no flush started
        if (bist_valid_i) begin
          state_d      = st_idle;
          flushed_we_o = 1'b1;
          flushed_d_o  = bist_res_i;
        end
      end
      st_idle: begin
        if (cfg_written_i) begin
          state_d = st_wait_iso;
        end
      end
      st_wait_iso: begin
        if (llc_isolated_i) begin
          state_d = st_wait_busy;
        end
      end
      st_wait_busy: begin
        // Descriptor units must drain before flush descriptors enter
        if (!aw_busy_i && !ar_busy_i) begin
          state_d = st_init;
        end
      end
      st_init: begin
        if (|flush_q_i) begin
          // Explicit flush request
          to_flush_d = flush_q_i & ~flushed_q_i;
        end else begin
          // SPM change, ways leaving SPM are no longer flushed
          to_flush_d   = spm_q_i & ~flushed_q_i;
          flushed_we_o = 1'b1;
          flushed_d_o  = spm_q_i & flushed_q_i;
        end
        if (to_flush_d == '0) begin
          state_d     = st_idle;
          flush_clr_o = 1'b1;
        end else begin
          state_d  = st_send;
          cnt_load = 1'b1;
        end
      end
      st_send: begin
        // Index only advances on an accepted descriptor
        if (flush_ready_i) begin
          send_inc = 1'b1;
          if (send_cnt_q == index_t'(num_lines - 1)) begin
            state_d = st_wait_done;
          end
        end
      end
      st_wait_done: begin
        if (outst_q == '0) begin
          state_d = st_end;
        end
      end
      st_end: begin
        flushed_we_o = 1'b1;
        if (to_flush_q == way_sel) begin
          // Last way done, back to the SPM view
          state_d     = st_idle;
          flushed_d_o = spm_q_i;
          flush_clr_o = 1'b1;
          to_flush_d  = '0;
        end else begin
          state_d     = st_init;
          flushed_d_o = flushed_q_i | way_sel;
        end
      end
      default: begin
        state_d = st_pre_init;
      end
    endcase
  end

  // Completions only counted while a way is in flight
  assign done_dec = flush_done_i & ((state_q == st_send) | (state_q == st_wait_done));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= st_pre_init;
      to_flush_q <= '0;
      send_cnt_q <= '0;
      outst_q    <= '0;
    end else begin
      state_q    <= state_d;
      to_flush_q <= to_flush_d;
      if (cnt_load) begin
        send_cnt_q <= '0;
        outst_q    <= outst_t'(num_lines);
      end else begin
        if (send_inc) begin
          send_cnt_q <= send_cnt_q + index_t'(1);
        end
        if (done_dec) begin
          outst_q <= outst_q - outst_t'(1);
        end
      end
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  // Port stays isolated and config locked outside idle
  assign llc_isolate_o = (state_q != st_idle);
  assign cfg_lock_o    = (state_q != st_idle);

  // BIST load of the SPM lock
  assign spm_we_o = (state_q == st_pre_init) & bist_valid_i;
  assign spm_d_o  = bist_res_i;

  // Descriptor, line index placed above the offset bits
  assign flush_valid_o = (state_q == st_send);
  assign flush_addr_o  = {{tag_len{1'b0}}, send_cnt_q, {`LLC_OFFSET_LEN{1'b0}}};
  assign flush_way_o   = way_sel;

endmodule

`default_nettype wire

//--- verilog/llc_bypass_sel.sv
// Bypass decision for the AW and AR addresses
// Regions are half-open, start inclusive and end exclusive
// SPM region wins where the two regions overlap

`include "llc_cfg_defines.svh"

`default_nettype none

module llc_bypass_sel (
  input  llc_cfg_pkg::addr_t aw_addr_i,
  input  llc_cfg_pkg::addr_t ar_addr_i,
  input  llc_cfg_pkg::addr_t spm_start_i,
  input  llc_cfg_pkg::addr_t spm_end_i,
  input  llc_cfg_pkg::addr_t cached_start_i,
  input  llc_cfg_pkg::addr_t cached_end_i,
  input  llc_cfg_pkg::way_t  flushed_i,
  output logic               aw_bypass_o,
  output logic               ar_bypass_o
);
  import llc_cfg_pkg::*;

  logic all_flushed;
  logic aw_in_spm, aw_in_cached;
  logic ar_in_spm, ar_in_cached;

  // Address hit inside one region
  function automatic logic in_region(addr_t addr, addr_t start_addr, addr_t end_addr);
    return (addr >= start_addr) && (addr < end_addr);
  endfunction

  // Whole cache flushed, cached traffic goes straight to memory
  assign all_flushed = &flushed_i;

  assign aw_in_spm    = in_region(aw_addr_i, spm_start_i, spm_end_i);
  assign aw_in_cached = in_region(aw_addr_i, cached_start_i, cached_end_i);
  assign ar_in_spm    = in_region(ar_addr_i, spm_start_i, spm_end_i);
  assign ar_in_cached = in_region(ar_addr_i, cached_start_i, cached_end_i);

  // SPM never bypasses, unmapped addresses always do
  assign aw_bypass_o = ~aw_in_spm & (~aw_in_cached | all_flushed);
  assign ar_bypass_o = ~ar_in_spm & (~ar_in_cached | all_flushed);

endmodule

`default_nettype wire

//--- verilog/llc_cfg_top.sv
// Top level of the LLC configuration and flush controller
// Plain register port, one write strobe per access, combinational read
// Cache port stays isolated after reset until bist_valid_i is seen

`include "llc_cfg_defines.svh"

`default_nettype none

module llc_cfg_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Register port
  input  logic                   cfg_we_i,
  input  llc_cfg_pkg::reg_idx_e  cfg_waddr_i,
  input  llc_cfg_pkg::reg_data_t cfg_wdata_i,
  input  llc_cfg_pkg::reg_idx_e  cfg_raddr_i,
  output llc_cfg_pkg::reg_data_t cfg_rdata_o,
  // Tag storage BIST
  input  logic                   bist_valid_i,
  input  llc_cfg_pkg::way_t      bist_res_i,
  // Cache port isolation and unit status
  output logic                   llc_isolate_o,
  input  logic                   llc_isolated_i,
  input  logic                   aw_busy_i,
  input  logic                   ar_busy_i,
  // Flush descriptors and completions
  output logic                   flush_valid_o,
  input  logic                   flush_ready_i,
  output llc_cfg_pkg::addr_t     flush_addr_o,
  output llc_cfg_pkg::way_t      flush_way_o,
  input  logic                   flush_done_i,
  // Bypass selection
  input  llc_cfg_pkg::addr_t     aw_addr_i,
  input  llc_cfg_pkg::addr_t     ar_addr_i,
  input  llc_cfg_pkg::addr_t     spm_start_i,
  input  llc_cfg_pkg::addr_t     spm_end_i,
  input  llc_cfg_pkg::addr_t     cached_start_i,
  input  llc_cfg_pkg::addr_t     cached_end_i,
  output logic                   aw_bypass_o,
  output logic                   ar_bypass_o,
  // Way state for the cache
  output llc_cfg_pkg::way_t      spm_lock_o,
  output llc_cfg_pkg::way_t      flushed_o
);
  import llc_cfg_pkg::*;

  // Bank to flush control
  logic cfg_written;
  way_t flush_q;
  // Flush control to bank
  logic cfg_lock;
  logic flushed_we;
  way_t flushed_d;
  logic flush_clr;
  logic spm_we;
  way_t spm_d;

  ////////////////////
  // Register bank
  ////////////////////

  // CfgSpm and Flushed drive the cache outputs directly
  llc_cfg_regs i_llc_cfg_regs (
    .clk_i         ( clk_i        ),
    .rst_n_i       ( rst_n_i      ),
    .cfg_we_i      ( cfg_we_i     ),
    .cfg_waddr_i   ( cfg_waddr_i  ),
    .cfg_wdata_i   ( cfg_wdata_i  ),
    .cfg_raddr_i   ( cfg_raddr_i  ),
    .cfg_rdata_o   ( cfg_rdata_o  ),
    .bist_valid_i  ( bist_valid_i ),
    .bist_res_i    ( bist_res_i   ),
    .cfg_lock_i    ( cfg_lock     ),
    .flushed_we_i  ( flushed_we   ),
    .flushed_d_i   ( flushed_d    ),
    .flush_clr_i   ( flush_clr    ),
    .spm_we_i      ( spm_we       ),
    .spm_d_i       ( spm_d        ),
    .cfg_written_o ( cfg_written  ),
    .spm_q_o       ( spm_lock_o   ),
    .flush_q_o     ( flush_q      ),
    .flushed_q_o   ( flushed_o    )
  );

  ////////////////////
  // Flush control
  ////////////////////

  llc_flush_ctrl i_llc_flush_ctrl (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .bist_valid_i   ( bist_valid_i   ),
    .bist_res_i     ( bist_res_i     ),
    .cfg_written_i  ( cfg_written    ),
    .spm_q_i        ( spm_lock_o     ),
    .flush_q_i      ( flush_q        ),
    .flushed_q_i    ( flushed_o      ),
    .llc_isolated_i ( llc_isolated_i ),
    .aw_busy_i      ( aw_busy_i      ),
    .ar_busy_i      ( ar_busy_i      ),
    .flush_ready_i  ( flush_ready_i  ),
    .flush_done_i   ( flush_done_i   ),
    .llc_isolate_o  ( llc_isolate_o  ),
    .cfg_lock_o     ( cfg_lock       ),
    .flushed_we_o   ( flushed_we     ),
    .flushed_d_o    ( flushed_d      ),
    .flush_clr_o    ( flush_clr      ),
    .spm_we_o       ( spm_we         ),
    .spm_d_o        ( spm_d          ),
    .flush_valid_o  ( flush_valid_o  ),
    .flush_addr_o   ( flush_addr_o   ),
    .flush_way_o    ( flush_way_o    )
  );

  // Bypass follows the live Flushed register
  llc_bypass_sel i_llc_bypass_sel (
    .aw_addr_i      ( aw_addr_i      ),
    .ar_addr_i      ( ar_addr_i      ),
    .spm_start_i    ( spm_start_i    ),
    .spm_end_i      ( spm_end_i      ),
    .cached_start_i ( cached_start_i ),
    .cached_end_i   ( cached_end_i   ),
    .flushed_i      ( flushed_o      ),
    .aw_bypass_o    ( aw_bypass_o    ),
    .ar_bypass_o    ( ar_bypass_o    )
  );

endmodule

`default_nettype wire

//--- tests/llc_cfg_tb.sv
// Table-driven testbench for the LLC configuration and flush controller
// Environment model acks isolation after two cycles and completes descriptors late
// Descriptor order is checked against the way mask of each flush step

`include "llc_cfg_defines.svh"

`default_nettype none

module llc_cfg_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import llc_cfg_pkg::*;

  localparam int clk_period    = 40;
  localparam int lines_per_way = 1 << `LLC_INDEX_LEN;
  localparam int flush_timeout = 2000;
  // Address map used by the bypass probes
  localparam addr_t spm_lo = 32'h1000_0000;
  localparam addr_t spm_hi = 32'h1001_0000;
  localparam addr_t cac_lo = 32'h8000_0000;
  localparam addr_t cac_hi = 32'hC000_0000;

  typedef enum logic [2:0] {
    op_write,
    op_write_locked,
    op_read,
    op_bist,
    op_flush,
    op_probe
  } op_e;

  // Unused fields of a table entry stay zero
  typedef struct packed {
    op_e       op;
    reg_idx_e  idx;
    reg_data_t data;
    way_t      ways;
    way_t      flushed;
    way_t      spm;
    addr_t     aw;
    addr_t     ar;
    logic      aw_byp;
    logic      ar_byp;
  } step_t;

  logic clk_i = 1'b0;
  logic rst_n_i;
  logic cfg_we_i;
  reg_idx_e cfg_waddr_i;
  reg_data_t cfg_wdata_i;
  reg_idx_e cfg_raddr_i;
  reg_data_t cfg_rdata_o;
  logic bist_valid_i;
  way_t bist_res_i;
  logic llc_isolate_o;
  logic llc_isolated_i = 1'b0;
  logic aw_busy_i = 1'b0;
  logic ar_busy_i = 1'b0;
  logic flush_valid_o;
  logic flush_ready_i = 1'b0;
  addr_t flush_addr_o;
  way_t flush_way_o;
  logic flush_done_i = 1'b0;
  addr_t aw_addr_i, ar_addr_i;
  addr_t spm_start_i, spm_end_i, cached_start_i, cached_end_i;
  logic aw_bypass_o, ar_bypass_o;
  way_t spm_lock_o, flushed_o;

  step_t steps[$];
  string names[$];
  addr_t cap_addr[$];
  way_t cap_way[$];
  int done_delay[$];
  int new_accepts = 0;
  logic [1:0] iso_pipe = 2'b00;
  logic hold_pending = 1'b0;
  addr_t hold_addr = '0;
  way_t hold_way = '0;

  always #(clk_period / 2) clk_i = ~clk_i;

  llc_cfg_top i_llc_cfg_top (.*);

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic stop_run();
    $display("Testbench failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
    if (act !== exp) begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_way(input string name, input way_t exp, input way_t act);
    if (act !== exp) begin
      $display("error %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s: expected %b, actual %b", name, exp, act);
      stop_run();
    end
  endtask

  ////////////////////
  // Environment model
  ////////////////////

  // Random ready, isolation ack two cycles late, completions after a random delay
  initial begin
    void'($urandom(32'h6569_b7f7));
    forever begin
      @(negedge clk_i);
      // Descriptor stalled at the last edge must stay put
      if (hold_pending) begin
        check_bit("descriptor valid held", 1'b1, flush_valid_o);
        check_addr("descriptor address held", hold_addr, flush_addr_o);
        check_way("descriptor way held", hold_way, flush_way_o);
      end
      flush_ready_i = ($urandom % 4) != 0;
      llc_isolated_i = iso_pipe[1] & llc_isolate_o;
      iso_pipe = {iso_pipe[0], llc_isolate_o};
      while (new_accepts > 0) begin
        done_delay.push_back(int'($urandom % 5) + 1);
        new_accepts--;
      end
      flush_done_i = 1'b0;
      if (done_delay.size() > 0) begin
        if (done_delay[0] <= 1) begin
          void'(done_delay.pop_front());
          flush_done_i = 1'b1;
        end else begin
          done_delay[0] = done_delay[0] - 1;
        end
      end
      // Valid and ready are settled here, the transfer happens at the next rising edge
      if (flush_valid_o && flush_ready_i) begin
        cap_addr.push_back(flush_addr_o);
        cap_way.push_back(flush_way_o);
        new_accepts++;
      end
      hold_pending = flush_valid_o && !flush_ready_i;
      hold_addr = flush_addr_o;
      hold_way = flush_way_o;
    end
  end

  ////////////////////
  // Table helpers
  ////////////////////

  task automatic add_op(input string name, input op_e op, input reg_idx_e idx,
                        input reg_data_t data);
    step_t s;
    s = '0;
    s.op = op;
    s.idx = idx;
    s.data = data;
    steps.push_back(s);
    names.push_back(name);
  endtask

  task automatic add_flush(input string name, input way_t ways, input way_t flushed,
                           input way_t spm);
    step_t s;
    s = '0;
    s.op = op_flush;
    s.ways = ways;
    s.flushed = flushed;
    s.spm = spm;
    steps.push_back(s);
    names.push_back(name);
  endtask

  task automatic add_probe(input string name, input addr_t aw, input addr_t ar,
                           input logic aw_byp, input logic ar_byp);
    step_t s;
    s = '0;
    s.op = op_probe;
    s.aw = aw;
    s.ar = ar;
    s.aw_byp = aw_byp;
    s.ar_byp = ar_byp;
    steps.push_back(s);
    names.push_back(name);
  endtask

  task automatic build_table();
    add_op("bist result", op_bist, reg_cfg_spm, 64'h2);
    add_op("read BistOut", op_read, reg_bist_out, 64'h2);
    add_op("read CfgSpm", op_read, reg_cfg_spm, 64'h2);
    add_op("read Flushed", op_read, reg_flushed, 64'h2);
    add_op("read SetAsso", op_read, reg_set_asso, 64'd4);
    add_op("read NumLines", op_read, reg_num_lines, 64'd16);
    add_op("read NumBlocks", op_read, reg_num_blocks, 64'd8);
    add_op("read Version", op_read, reg_version, `LLC_VERSION);
    // Read-only registers keep their value
    add_op("write Flushed", op_write, reg_flushed, '1);
    add_op("write BistOut", op_write, reg_bist_out, '1);
    add_op("write SetAsso", op_write, reg_set_asso, '1);
    add_op("write Version", op_write, reg_version, '0);
    add_op("reread Flushed", op_read, reg_flushed, 64'h2);
    add_op("reread BistOut", op_read, reg_bist_out, 64'h2);
    add_op("reread SetAsso", op_read, reg_set_asso, 64'd4);
    add_op("reread Version", op_read, reg_version, `LLC_VERSION);
    // Cache not fully flushed yet
    add_probe("probe spm region", spm_lo, spm_hi - 32'd1, 1'b0, 1'b0);
    add_probe("probe outside", 32'h0, spm_hi, 1'b1, 1'b1);
    add_probe("probe cached", cac_lo, cac_hi - 32'd1, 1'b0, 1'b0);
    add_probe("probe cached end", cac_hi, cac_lo + 32'h40, 1'b1, 1'b0);
    // Explicit flush with writes landing while it runs
    add_op("write CfgFlush", op_write, reg_cfg_flush, 64'h5);
    add_op("CfgFlush during flush", op_write_locked, reg_cfg_flush, 64'hA);
    add_op("CfgSpm during flush", op_write_locked, reg_cfg_spm, 64'hF);
    add_flush("flush ways 0101", 4'b0101, 4'b0010, 4'b0010);
    add_op("read CfgFlush cleared", op_read, reg_cfg_flush, 64'h0);
    add_op("read CfgSpm unchanged", op_read, reg_cfg_spm, 64'h2);
    add_op("read Flushed after flush", op_read, reg_flushed, 64'h2);
    // SPM changes
    add_op("write CfgSpm 1100", op_write, reg_cfg_spm, 64'hC);
    add_flush("spm flush 1100", 4'b1100, 4'b1100, 4'b1100);
    add_op("read Flushed 1100", op_read, reg_flushed, 64'hC);
    add_op("write CfgSpm ones", op_write, reg_cfg_spm, '1);
    add_flush("spm flush all", 4'b0011, 4'b1111, 4'b1111);
    add_op("read CfgSpm masked", op_read, reg_cfg_spm, 64'hF);
    add_op("read Flushed all", op_read, reg_flushed, 64'hF);
    // Cached region bypasses once all ways are flushed
    add_probe("probe cached flushed", cac_lo + 32'h100, cac_hi - 32'h40, 1'b1, 1'b1);
    add_probe("probe spm flushed", spm_lo + 32'h8, spm_lo, 1'b0, 1'b0);
    add_probe("probe outside flushed", spm_hi, 32'hF000_0000, 1'b1, 1'b1);
  endtask

  ////////////////////
  // Step tasks
  ////////////////////

  task automatic do_write(input reg_idx_e idx, input reg_data_t data);
    cfg_we_i = 1'b1;
    cfg_waddr_i = idx;
    cfg_wdata_i = data;
    @(negedge clk_i);
    cfg_we_i = 1'b0;
  endtask

  task automatic wait_isolation_drop(input string name);
    int cycles;
    cycles = 0;
    while (llc_isolate_o) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > flush_timeout) begin
        $display("isolation still active after %0d cycles in step %s", cycles, name);
        stop_run();
      end
    end
  endtask

  // Expected order is lowest way first with line indices 0 to 15
  task automatic check_descriptors(input string name, input way_t ways);
    int n;
    int exp_count;
    addr_t exp_addr;
    way_t exp_way;
    exp_count = 0;
    for (int w = 0; w < `LLC_SET_ASSO; w++) begin
      if (ways[w]) begin
        exp_count += lines_per_way;
      end
    end
    check_data({name, " descriptor count"}, reg_data_t'(exp_count),
               reg_data_t'(cap_addr.size()));
    n = 0;
    for (int w = 0; w < `LLC_SET_ASSO; w++) begin
      if (ways[w]) begin
        for (int i = 0; i < lines_per_way; i++) begin
          exp_addr = addr_t'(i) << `LLC_OFFSET_LEN;
          exp_way = way_t'(1) << w;
          check_addr({name, " descriptor address"}, exp_addr, cap_addr[n]);
          check_way({name, " descriptor way"}, exp_way, cap_way[n]);
          n++;
        end
      end
    end
    cap_addr.delete();
    cap_way.delete();
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    step_t s;
    string name;
    rst_n_i = 1'b0;
    cfg_we_i = 1'b0;
    cfg_waddr_i = reg_cfg_spm;
    cfg_wdata_i = '0;
    cfg_raddr_i = reg_cfg_spm;
    bist_valid_i = 1'b0;
    bist_res_i = '0;
    aw_addr_i = '0;
    ar_addr_i = '0;
    spm_start_i = spm_lo;
    spm_end_i = spm_hi;
    cached_start_i = cac_lo;
    cached_end_i = cac_hi;
    build_table();
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    // Pre-init state until the BIST result arrives
    check_bit("reset isolate", 1'b1, llc_isolate_o);
    check_bit("reset flush valid", 1'b0, flush_valid_o);
    check_way("reset spm lock", '0, spm_lock_o);
    check_way("reset flushed", '0, flushed_o);
    for (int k = 0; k < steps.size(); k++) begin
      s = steps[k];
      name = names[k];
      case (s.op)
        op_write: begin
          do_write(s.idx, s.data);
        end
        op_write_locked: begin
          check_bit({name, " lock"}, 1'b1, llc_isolate_o);
          do_write(s.idx, s.data);
        end
        op_read: begin
          cfg_raddr_i = s.idx;
          #(clk_period / 4);
          check_data(name, s.data, cfg_rdata_o);
          @(negedge clk_i);
        end
        op_bist: begin
          bist_valid_i = 1'b1;
          bist_res_i = s.data[`LLC_SET_ASSO-1:0];
          @(negedge clk_i);
          bist_valid_i = 1'b0;
          wait_isolation_drop(name);
          check_way({name, " spm lock"}, s.data[`LLC_SET_ASSO-1:0], spm_lock_o);
          check_way({name, " flushed"}, s.data[`LLC_SET_ASSO-1:0], flushed_o);
          check_descriptors(name, '0);
        end
        op_flush: begin
          wait_isolation_drop(name);
          check_descriptors(name, s.ways);
          check_way({name, " flushed"}, s.flushed, flushed_o);
          check_way({name, " spm lock"}, s.spm, spm_lock_o);
        end
        default: begin
          aw_addr_i = s.aw;
          ar_addr_i = s.ar;
          #(clk_period / 4);
          check_bit({name, " aw bypass"}, s.aw_byp, aw_bypass_o);
          check_bit({name, " ar bypass"}, s.ar_byp, ar_bypass_o);
          @(negedge clk_i);
        end
      endcase
    end
    check_data("stray descriptors", '0, reg_data_t'(cap_addr.size()));
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+verilog
verilog/llc_cfg_pkg.sv
verilog/llc_cfg_regs.sv
verilog/llc_flush_ctrl.sv
verilog/llc_bypass_sel.sv
verilog/llc_cfg_top.sv
tests/llc_cfg_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the LLC configuration testbench with Verilator.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module llc_cfg_tb \
  -Mdir obj_dir -o sim_llc_cfg
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_llc_cfg > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench passed" sim.log; then
  echo "result: PASS"
  exit 0
else
  echo "result: FAIL"
  exit 1
fi
